// File: rtl/pathOram_config.svh
//--------------------------------------------------------------------
// Tree size and DDR3 widths for simulation builds
// DDR_M_WIDTH must stay DDR_D_WIDTH / 8
//--------------------------------------------------------------------
`ifndef PATHORAM_CONFIG_SVH
`define PATHORAM_CONFIG_SVH

// Buckets in the ORAM tree, small so init ends quickly in simulation
`define ORAM_NUM_BUCKETS 15

// DDR3 native interface widths
`define DDR_A_WIDTH 28
`define DDR_C_WIDTH 3
`define DDR_D_WIDTH 512
`define DDR_M_WIDTH 64

// Bucket footprint in DDR words, also the header address step
`define BKT_DDR_WORDS 4

// Header layout
`define IV_ENTROPY_WIDTH 64
// One valid bit per block slot
`define BKT_VALID_BITS 4

`endif

// File: rtl/pathOramPkg.sv
//--------------------------------------------------------------------
// Shared types and derived constants for the DRAM front end
//--------------------------------------------------------------------
`include "pathOram_config.svh"

package pathOramPkg;

	//--------------------------------------------------------------------
	// Types
	//--------------------------------------------------------------------

	// DDR3 native command opcodes
	typedef enum logic [`DDR_C_WIDTH-1:0] {
		cmdWrite = `DDR_C_WIDTH'(0),
		cmdRead  = `DDR_C_WIDTH'(1)
	} ddrCmdE;

	// Owner of the DDR3 channels
	typedef enum logic {
		modeInit = 1'b0,
		modeRun  = 1'b1
	} arbModeE;

	//--------------------------------------------------------------------
	// Derived constants
	//--------------------------------------------------------------------

	// First address past the last bucket header
	localparam logic [`DDR_A_WIDTH-1:0] endOfTreeAddr =
		`DDR_A_WIDTH'(`BKT_DDR_WORDS * `ORAM_NUM_BUCKETS);

	// Header bits left after both IVs and the valid bits
	localparam int spaceRemaining =
		`DDR_D_WIDTH - 2 * `IV_ENTROPY_WIDTH - `BKT_VALID_BITS;

endpackage

// File: rtl/dramInitializer.sv
//--------------------------------------------------------------------
// Writes one cleared header per bucket once DDR3 calibration is done
// IV fields are written as zero, no encryption in this path
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "pathOram_config.svh"

module dramInitializer (
	input  logic                         Clock,
	input  logic                         rstN,

	// Command channel
	output logic [`DDR_A_WIDTH-1:0]      initCmdAddr,
	output pathOramPkg::ddrCmdE          initCmd,
	output logic                         initCmdValid,
	input  logic                         initCmdReady,

	// Write data channel
	output logic [`DDR_D_WIDTH-1:0]      initWrData,
	output logic [`DDR_M_WIDTH-1:0]      initWrMask,
	output logic                         initWrValid,
	input  logic                         initWrReady,

	// Status
	output logic                         initDone
);

	//--------------------------------------------------------------------
	// Constants
	//--------------------------------------------------------------------

	// Address distance between consecutive bucket headers
	localparam logic [`DDR_A_WIDTH-1:0] addrStep = `DDR_A_WIDTH'(`BKT_DDR_WORDS);

	// Header fields, all zero
	localparam logic [`IV_ENTROPY_WIDTH-1:0] ivField = '0;
	localparam logic [`BKT_VALID_BITS-1:0] validField = '0;
	localparam logic [pathOramPkg::spaceRemaining-1:0] spaceField = '0;

	//--------------------------------------------------------------------
	// Stepping counters
	//--------------------------------------------------------------------

	// Command address counter doubles as the command address
	logic [`DDR_A_WIDTH-1:0] cmdCount;
	// Separate data counter lets commands run ahead of data
	logic [`DDR_A_WIDTH-1:0] wrCount;
	logic                    cmdFire;
	logic                    wrFire;

	assign cmdFire = initCmdValid & initCmdReady;
	assign wrFire = initWrValid & initWrReady;

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			cmdCount <= '0;
		end else if (cmdFire) begin
			cmdCount <= cmdCount + addrStep;
		end
	end

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			wrCount <= '0;
		end else if (wrFire) begin
			wrCount <= wrCount + addrStep;
		end
	end

	//--------------------------------------------------------------------
	// Channel outputs
	//--------------------------------------------------------------------

	// Each valid drops once its own counter hits the end of tree
	assign initCmdValid = (cmdCount != pathOramPkg::endOfTreeAddr);
	assign initWrValid = (wrCount != pathOramPkg::endOfTreeAddr);

	// Counters freeze at the end, so done holds until reset
	assign initDone = ~initCmdValid & ~initWrValid;

	assign initCmdAddr = cmdCount;
	assign initCmd = pathOramPkg::cmdWrite;

	// IV, valid bits, second IV, remaining space
	assign initWrData = {ivField, validField, ivField, spaceField};
	// Mask bit low means byte enabled
	assign initWrMask = '0;

	//--------------------------------------------------------------------
	// Assertions
	//--------------------------------------------------------------------

	// Counters never step past the last bucket
	cmdCountBound: assert property (@(posedge Clock) disable iff (!rstN)
		cmdCount <= pathOramPkg::endOfTreeAddr);

	wrCountBound: assert property (@(posedge Clock) disable iff (!rstN)
		wrCount <= pathOramPkg::endOfTreeAddr);

	// Done is sticky until the next reset
	doneSticky: assert property (@(posedge Clock) disable iff (!rstN)
		initDone |=> initDone);

endmodule

// File: rtl/dramCmdArbiter.sv
//--------------------------------------------------------------------
// Hands the DDR3 channels to the initializer, then to the ORAM side
// Pass-through is combinational, no buffering on either path
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "pathOram_config.svh"

module dramCmdArbiter (
	input  logic                         Clock,
	input  logic                         rstN,
	input  logic                         initDone,

	// Initializer channels
	input  logic [`DDR_A_WIDTH-1:0]      initCmdAddr,
	input  pathOramPkg::ddrCmdE          initCmd,
	input  logic                         initCmdValid,
	output logic                         initCmdReady,
	input  logic [`DDR_D_WIDTH-1:0]      initWrData,
	input  logic [`DDR_M_WIDTH-1:0]      initWrMask,
	input  logic                         initWrValid,
	output logic                         initWrReady,

	// ORAM controller channels
	input  logic [`DDR_A_WIDTH-1:0]      oramCmdAddr,
	input  pathOramPkg::ddrCmdE          oramCmd,
	input  logic                         oramCmdValid,
	output logic                         oramCmdReady,
	input  logic [`DDR_D_WIDTH-1:0]      oramWrData,
	input  logic [`DDR_M_WIDTH-1:0]      oramWrMask,
	input  logic                         oramWrValid,
	output logic                         oramWrReady,

	// DDR3 channels
	output logic [`DDR_A_WIDTH-1:0]      ddrCmdAddr,
	output pathOramPkg::ddrCmdE          ddrCmd,
	output logic                         ddrCmdValid,
	input  logic                         ddrCmdReady,
	output logic [`DDR_D_WIDTH-1:0]      ddrWrData,
	output logic [`DDR_M_WIDTH-1:0]      ddrWrMask,
	output logic                         ddrWrValid,
	input  logic                         ddrWrReady,

	output logic                         oramReady
);

	//--------------------------------------------------------------------
	// Mode register
	//--------------------------------------------------------------------

	pathOramPkg::arbModeE mode;
	logic                 runMode;

	// One-way switch, init never comes back without reset
	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			mode <= pathOramPkg::modeInit;
		end else if (initDone) begin
			mode <= pathOramPkg::modeRun;
		end
	end

	assign runMode = (mode == pathOramPkg::modeRun);
	assign oramReady = runMode;

	//--------------------------------------------------------------------
	// Channel select
	//--------------------------------------------------------------------

	always_comb begin
		if (runMode) begin
			ddrCmdAddr  = oramCmdAddr;
			ddrCmd      = oramCmd;
			ddrCmdValid = oramCmdValid;
			ddrWrData   = oramWrData;
			ddrWrMask   = oramWrMask;
			ddrWrValid  = oramWrValid;
		end else begin
			ddrCmdAddr  = initCmdAddr;
			ddrCmd      = initCmd;
			ddrCmdValid = initCmdValid;
			ddrWrData   = initWrData;
			ddrWrMask   = initWrMask;
			ddrWrValid  = initWrValid;
		end
	end

	// Readies go back only to the current owner
	assign oramCmdReady = runMode & ddrCmdReady;
	assign oramWrReady = runMode & ddrWrReady;
	assign initCmdReady = ~runMode & ddrCmdReady;
	assign initWrReady = ~runMode & ddrWrReady;

	//--------------------------------------------------------------------
	// Assertions
	//--------------------------------------------------------------------

	// Leaving init requires the initializer to be finished
	modeNeedsDone: assert property (@(posedge Clock) disable iff (!rstN)
		(mode == pathOramPkg::modeInit) && !initDone |=> (mode == pathOramPkg::modeInit));

	// ORAM side sees no ready while init owns DDR3
	noOramReadyInInit: assert property (@(posedge Clock) disable iff (!rstN)
		(mode == pathOramPkg::modeInit) |-> !oramCmdReady && !oramWrReady);

endmodule

// File: rtl/oramDramFrontEnd.sv
//--------------------------------------------------------------------
// DRAM front end, tree init then ORAM pass-through to DDR3
// oramReady stays low until every bucket header has been written
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "pathOram_config.svh"

module oramDramFrontEnd (
	input  logic                         Clock,
	input  logic                         rstN,

	// ORAM controller side
	input  logic [`DDR_A_WIDTH-1:0]      oramCmdAddr,
	input  pathOramPkg::ddrCmdE          oramCmd,
	input  logic                         oramCmdValid,
	output logic                         oramCmdReady,
	input  logic [`DDR_D_WIDTH-1:0]      oramWrData,
	input  logic [`DDR_M_WIDTH-1:0]      oramWrMask,
	input  logic                         oramWrValid,
	output logic                         oramWrReady,

	// DDR3 side
	output logic [`DDR_A_WIDTH-1:0]      ddrCmdAddr,
	output pathOramPkg::ddrCmdE          ddrCmd,
	output logic                         ddrCmdValid,
	input  logic                         ddrCmdReady,
	output logic [`DDR_D_WIDTH-1:0]      ddrWrData,
	output logic [`DDR_M_WIDTH-1:0]      ddrWrMask,
	output logic                         ddrWrValid,
	input  logic                         ddrWrReady,

	output logic                         oramReady
);

	//--------------------------------------------------------------------
	// Initializer to arbiter
	//--------------------------------------------------------------------

	logic [`DDR_A_WIDTH-1:0] initCmdAddr;
	pathOramPkg::ddrCmdE     initCmd;
	logic                    initCmdValid;
	logic                    initCmdReady;
	logic [`DDR_D_WIDTH-1:0] initWrData;
	logic [`DDR_M_WIDTH-1:0] initWrMask;
	logic                    initWrValid;
	logic                    initWrReady;
	logic                    initDone;

	dramInitializer init_i (
		.Clock        (Clock),
		.rstN         (rstN),
		.initCmdAddr  (initCmdAddr),
		.initCmd      (initCmd),
		.initCmdValid (initCmdValid),
		.initCmdReady (initCmdReady),
		.initWrData   (initWrData),
		.initWrMask   (initWrMask),
		.initWrValid  (initWrValid),
		.initWrReady  (initWrReady),
		.initDone     (initDone)
	);

	// Owns the DDR3 channels
	dramCmdArbiter arb_i (
		.Clock        (Clock),
		.rstN         (rstN),
		.initDone     (initDone),
		.initCmdAddr  (initCmdAddr),
		.initCmd      (initCmd),
		.initCmdValid (initCmdValid),
		.initCmdReady (initCmdReady),
		.initWrData   (initWrData),
		.initWrMask   (initWrMask),
		.initWrValid  (initWrValid),
		.initWrReady  (initWrReady),
		.oramCmdAddr  (oramCmdAddr),
		.oramCmd      (oramCmd),
		.oramCmdValid (oramCmdValid),
		.oramCmdReady (oramCmdReady),
		.oramWrData   (oramWrData),
		.oramWrMask   (oramWrMask),
		.oramWrValid  (oramWrValid),
		.oramWrReady  (oramWrReady),
		.ddrCmdAddr   (ddrCmdAddr),
		.ddrCmd       (ddrCmd),
		.ddrCmdValid  (ddrCmdValid),
		.ddrCmdReady  (ddrCmdReady),
		.ddrWrData    (ddrWrData),
		.ddrWrMask    (ddrWrMask),
		.ddrWrValid   (ddrWrValid),
		.ddrWrReady   (ddrWrReady),
		.oramReady    (oramReady)
	);

endmodule

// File: dv/tbChecker.sv
//--------------------------------------------------------------------
// Transfer checker for the DRAM front end, samples on rising edges
// Init headers expected at steps of BKT_DDR_WORDS, all zero, mask zero
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "pathOram_config.svh"

module tbChecker #(
	parameter int numOramXfers = 40
) (
	input  logic                         Clock,
	input  logic                         rstN,
	input  logic [`DDR_A_WIDTH-1:0]      oramCmdAddr,
	input  pathOramPkg::ddrCmdE          oramCmd,
	input  logic                         oramCmdValid,
	input  logic                         oramCmdReady,
	input  logic [`DDR_D_WIDTH-1:0]      oramWrData,
	input  logic [`DDR_M_WIDTH-1:0]      oramWrMask,
	input  logic                         oramWrValid,
	input  logic                         oramWrReady,
	input  logic [`DDR_A_WIDTH-1:0]      ddrCmdAddr,
	input  pathOramPkg::ddrCmdE          ddrCmd,
	input  logic                         ddrCmdValid,
	input  logic                         ddrCmdReady,
	input  logic [`DDR_D_WIDTH-1:0]      ddrWrData,
	input  logic [`DDR_M_WIDTH-1:0]      ddrWrMask,
	input  logic                         ddrWrValid,
	input  logic                         ddrWrReady,
	input  logic                         oramReady,
	input  logic                         endOfTest,
	output int                           errorCount,
	output int                           compareCount
);

	localparam int numBuckets = `ORAM_NUM_BUCKETS;

	// Transfer counts per source
	int initCmdSeen;
	int initWrSeen;
	int oramCmdSeen;
	int oramWrSeen;
	logic readySeen;
	logic endChecked;

	// Payload of a stalled valid, must not move
	logic cmdHeld;
	logic wrHeld;
	logic [`DDR_A_WIDTH-1:0] heldAddr;
	pathOramPkg::ddrCmdE heldCmd;
	logic [`DDR_D_WIDTH-1:0] heldData;
	logic [`DDR_M_WIDTH-1:0] heldMask;

	// Accepted ORAM traffic still to show up on DDR3
	logic [`DDR_A_WIDTH-1:0] expAddrQ[$];
	pathOramPkg::ddrCmdE expCmdQ[$];
	logic [`DDR_D_WIDTH-1:0] expDataQ[$];
	logic [`DDR_M_WIDTH-1:0] expMaskQ[$];

	task automatic reportMismatch(input string testName, input logic [511:0] expected,
		input logic [511:0] actual);
		errorCount++;
		$display("ERROR %s expected %0h actual %0h at %0t", testName, expected, actual, $time);
	endtask

	task automatic reportFailure(input string what);
		errorCount++;
		$display("Failure at %0t: %s", $time, what);
	endtask

	//--------------------------------------------------------------------
	// Per-transfer comparison
	//--------------------------------------------------------------------

	task automatic checkCmdTransfer();
		logic [`DDR_A_WIDTH-1:0] expAddr;
		pathOramPkg::ddrCmdE expCmd;
		string testName;
		if (!oramReady) begin
			// Header k lives at k times the bucket step
			expAddr = `DDR_A_WIDTH'(initCmdSeen * `BKT_DDR_WORDS);
			expCmd = pathOramPkg::cmdWrite;
			testName = "initCmd";
			if (initCmdSeen >= numBuckets) begin
				reportFailure("initializer sent a command past the last bucket");
			end
			initCmdSeen++;
		end else if (expAddrQ.size() == 0) begin
			reportFailure("DDR3 accepted a command that the ORAM side never offered");
			return;
		end else begin
			expAddr = expAddrQ.pop_front();
			expCmd = expCmdQ.pop_front();
			testName = "oramCmd";
			oramCmdSeen++;
		end
		compareCount++;
		if (ddrCmdAddr !== expAddr) begin
			reportMismatch({testName, "Addr"}, expAddr, ddrCmdAddr);
		end
		if (ddrCmd !== expCmd) begin
			reportMismatch({testName, "Opcode"}, expCmd, ddrCmd);
		end
	endtask

	task automatic checkWrTransfer();
		logic [`DDR_D_WIDTH-1:0] expData;
		logic [`DDR_M_WIDTH-1:0] expMask;
		string testName;
		if (!oramReady) begin
			// Cleared header, every byte written
			expData = '0;
			expMask = '0;
			testName = "initWr";
			if (initWrSeen >= numBuckets) begin
				reportFailure("initializer sent a data word past the last bucket");
			end
			initWrSeen++;
		end else if (expDataQ.size() == 0) begin
			reportFailure("DDR3 accepted a data word that the ORAM side never offered");
			return;
		end else begin
			expData = expDataQ.pop_front();
			expMask = expMaskQ.pop_front();
			testName = "oramWr";
			oramWrSeen++;
		end
		compareCount++;
		if (ddrWrData !== expData) begin
			reportMismatch({testName, "Data"}, expData, ddrWrData);
		end
		if (ddrWrMask !== expMask) begin
			reportMismatch({testName, "Mask"}, expMask, ddrWrMask);
		end
	endtask

	task automatic checkEnd();
		if (!readySeen) begin
			reportFailure("oramReady never rose");
		end
		if (initCmdSeen != numBuckets) begin
			reportMismatch("initCmdCount", numBuckets, initCmdSeen);
		end
		if (initWrSeen != numBuckets) begin
			reportMismatch("initWrCount", numBuckets, initWrSeen);
		end
		if (oramCmdSeen != numOramXfers) begin
			reportMismatch("oramCmdCount", numOramXfers, oramCmdSeen);
		end
		if (oramWrSeen != numOramXfers) begin
			reportMismatch("oramWrCount", numOramXfers, oramWrSeen);
		end
	endtask

	//--------------------------------------------------------------------
	// Rising edge sampling
	//--------------------------------------------------------------------

	always @(posedge Clock) begin
		if (!rstN) begin
			errorCount = 0;
			compareCount = 0;
			initCmdSeen = 0;
			initWrSeen = 0;
			oramCmdSeen = 0;
			oramWrSeen = 0;
			readySeen = 1'b0;
			endChecked = 1'b0;
			cmdHeld = 1'b0;
			wrHeld = 1'b0;
		end else begin
			// ORAM side blocked until init is over
			if (!oramReady && (oramCmdReady || oramWrReady)) begin
				reportFailure("ORAM-side ready was high before init finished");
			end
			if (oramReady && (oramCmdReady !== ddrCmdReady)) begin
				reportMismatch("oramCmdReady", ddrCmdReady, oramCmdReady);
			end
			if (oramReady && (oramWrReady !== ddrWrReady)) begin
				reportMismatch("oramWrReady", ddrWrReady, oramWrReady);
			end

			// First cycle of run mode, both init counts must be complete
			if (oramReady && !readySeen) begin
				readySeen = 1'b1;
				if (initCmdSeen != numBuckets || initWrSeen != numBuckets) begin
					reportFailure("oramReady rose before all bucket headers were written");
				end
			end
			if (!oramReady && readySeen) begin
				reportFailure("oramReady fell after init finished");
			end

			// Stalled payloads stay put
			if (cmdHeld && (!ddrCmdValid || ddrCmdAddr !== heldAddr || ddrCmd !== heldCmd)) begin
				reportFailure("DDR3 command dropped or changed while stalled");
			end
			if (wrHeld && (!ddrWrValid || ddrWrData !== heldData || ddrWrMask !== heldMask)) begin
				reportFailure("DDR3 write data dropped or changed while stalled");
			end
			cmdHeld = ddrCmdValid && !ddrCmdReady;
			wrHeld = ddrWrValid && !ddrWrReady;
			heldAddr = ddrCmdAddr;
			heldCmd = ddrCmd;
			heldData = ddrWrData;
			heldMask = ddrWrMask;

			if (oramCmdValid && oramCmdReady) begin
				expAddrQ.push_back(oramCmdAddr);
				expCmdQ.push_back(oramCmd);
			end
			if (oramWrValid && oramWrReady) begin
				expDataQ.push_back(oramWrData);
				expMaskQ.push_back(oramWrMask);
			end
			if (ddrCmdValid && ddrCmdReady) begin
				checkCmdTransfer();
			end
			if (ddrWrValid && ddrWrReady) begin
				checkWrTransfer();
			end

			if (endOfTest && !endChecked) begin
				endChecked = 1'b1;
				checkEnd();
			end
		end
	end

endmodule

// File: dv/tbTop.sv
//--------------------------------------------------------------------
// Testbench for the DRAM front end, DDR3 modeled as random readies
// Inputs change on falling edges, checking is done in tbChecker
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "pathOram_config.svh"

module tbTop;

	localparam int numOramXfers = 40;
	// 20 cycles per bucket and per ORAM transfer, plus margin
	localparam int watchdogCycles = 20 * `ORAM_NUM_BUCKETS + 20 * numOramXfers + 100;

	logic                    Clock;
	logic                    rstN;
	logic [`DDR_A_WIDTH-1:0] oramCmdAddr;
	pathOramPkg::ddrCmdE     oramCmd;
	logic                    oramCmdValid;
	logic                    oramCmdReady;
	logic [`DDR_D_WIDTH-1:0] oramWrData;
	logic [`DDR_M_WIDTH-1:0] oramWrMask;
	logic                    oramWrValid;
	logic                    oramWrReady;
	logic [`DDR_A_WIDTH-1:0] ddrCmdAddr;
	pathOramPkg::ddrCmdE     ddrCmd;
	logic                    ddrCmdValid;
	logic                    ddrCmdReady;
	logic [`DDR_D_WIDTH-1:0] ddrWrData;
	logic [`DDR_M_WIDTH-1:0] ddrWrMask;
	logic                    ddrWrValid;
	logic                    ddrWrReady;
	logic                    oramReady;
	logic                    endOfTest;
	int                      errorCount;
	int                      compareCount;
	logic [31:0]             lcgState;

	//--------------------------------------------------------------------
	// Random source
	//--------------------------------------------------------------------

	function automatic logic [31:0] lcgStep(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic drawRandom(output logic [31:0] value);
		lcgState = lcgStep(lcgState);
		value = lcgState;
	endtask

	task automatic offerCommand();
		logic [31:0] r;
		drawRandom(r);
		oramCmdAddr = r[`DDR_A_WIDTH-1:0];
		oramCmd = r[31] ? pathOramPkg::cmdRead : pathOramPkg::cmdWrite;
		oramCmdValid = 1'b1;
	endtask

	task automatic offerWrite();
		logic [31:0] r;
		for (int i = 0; i < `DDR_D_WIDTH / 32; i++) begin
			drawRandom(r);
			oramWrData[i*32 +: 32] = r;
		end
		for (int i = 0; i < `DDR_M_WIDTH / 32; i++) begin
			drawRandom(r);
			oramWrMask[i*32 +: 32] = r;
		end
		oramWrValid = 1'b1;
	endtask

	//--------------------------------------------------------------------
	// Clock, DUT and checker
	//--------------------------------------------------------------------

	initial begin
		Clock = 1'b0;
		forever #10 Clock = ~Clock;
	end

	oramDramFrontEnd dut_i (
		.Clock(Clock), .rstN(rstN),
		.oramCmdAddr(oramCmdAddr), .oramCmd(oramCmd),
		.oramCmdValid(oramCmdValid), .oramCmdReady(oramCmdReady),
		.oramWrData(oramWrData), .oramWrMask(oramWrMask),
		.oramWrValid(oramWrValid), .oramWrReady(oramWrReady),
		.ddrCmdAddr(ddrCmdAddr), .ddrCmd(ddrCmd),
		.ddrCmdValid(ddrCmdValid), .ddrCmdReady(ddrCmdReady),
		.ddrWrData(ddrWrData), .ddrWrMask(ddrWrMask),
		.ddrWrValid(ddrWrValid), .ddrWrReady(ddrWrReady),
		.oramReady(oramReady)
	);

	tbChecker #(.numOramXfers(numOramXfers)) monitor_i (
		.Clock(Clock), .rstN(rstN),
		.oramCmdAddr(oramCmdAddr), .oramCmd(oramCmd),
		.oramCmdValid(oramCmdValid), .oramCmdReady(oramCmdReady),
		.oramWrData(oramWrData), .oramWrMask(oramWrMask),
		.oramWrValid(oramWrValid), .oramWrReady(oramWrReady),
		.ddrCmdAddr(ddrCmdAddr), .ddrCmd(ddrCmd),
		.ddrCmdValid(ddrCmdValid), .ddrCmdReady(ddrCmdReady),
		.ddrWrData(ddrWrData), .ddrWrMask(ddrWrMask),
		.ddrWrValid(ddrWrValid), .ddrWrReady(ddrWrReady),
		.oramReady(oramReady), .endOfTest(endOfTest),
		.errorCount(errorCount), .compareCount(compareCount)
	);

	//--------------------------------------------------------------------
	// Stimulus
	//--------------------------------------------------------------------

	initial begin
		logic [31:0] r;
		int cmdSent;
		int wrSent;
		lcgState = 32'hfbb6;
		rstN = 1'b0;
		ddrCmdReady = 1'b0;
		ddrWrReady = 1'b0;
		oramCmdAddr = '0;
		oramCmd = pathOramPkg::cmdWrite;
		oramCmdValid = 1'b0;
		oramWrData = '0;
		oramWrMask = '0;
		oramWrValid = 1'b0;
		endOfTest = 1'b0;
		cmdSent = 0;
		wrSent = 0;
		repeat (3) @(posedge Clock);
		@(negedge Clock);
		rstN = 1'b1;
		while (cmdSent < numOramXfers || wrSent < numOramXfers) begin
			// Handshakes that completed on the last rising edge
			if (oramCmdValid && oramCmdReady) begin
				cmdSent++;
				oramCmdValid = 1'b0;
			end
			if (oramWrValid && oramWrReady) begin
				wrSent++;
				oramWrValid = 1'b0;
			end
			drawRandom(r);
			// ORAM traffic only once init has handed over
			if (oramReady && !oramCmdValid && cmdSent < numOramXfers && r[20]) begin
				offerCommand();
			end
			if (oramReady && !oramWrValid && wrSent < numOramXfers && r[22]) begin
				offerWrite();
			end
			// DDR3 back-pressure, each ready about half the time
			ddrCmdReady = r[16];
			ddrWrReady = r[18];
			@(negedge Clock);
		end
		repeat (4) @(negedge Clock);
		endOfTest = 1'b1;
		@(negedge Clock);
		$display("Checks finished with %0d errors over %0d compared transfers",
			errorCount, compareCount);
		if (errorCount == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		repeat (watchdogCycles) @(posedge Clock);
		$display("Watchdog expired after %0d cycles, the run did not finish", watchdogCycles);
		$display("Test FAILED");
		$finish;
	end

endmodule

// File: build.f
+incdir+rtl
rtl/pathOramPkg.sv
rtl/dramInitializer.sv
rtl/dramCmdArbiter.sv
rtl/oramDramFrontEnd.sv
dv/tbChecker.sv
dv/tbTop.sv

// File: Bender.yml
package:
  name: path_oram_dram_frontend

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/pathOramPkg.sv
      - rtl/dramInitializer.sv
      - rtl/dramCmdArbiter.sv
      - rtl/oramDramFrontEnd.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/tbChecker.sv
      - dv/tbTop.sv
